/* gpioPkg.sv */
`default_nettype none

package gpioPkg;

	// ------------------------------
	// Widths
	// ------------------------------
	localparam int GpioWidth      = 5;
	localparam int SwNum          = 7;
	localparam int DipNum         = 2;
	localparam int BusWidth       = 32;
	localparam int CsrOffsetWidth = 8;
	localparam int BlockIdWidth   = 8;
	// Block ID sits right above the offset byte
	localparam int BlockIdLsb     = 8;

	typedef logic [BusWidth-1:0]       busWord_t;
	typedef logic [GpioWidth-1:0]      gpioVec_t;
	typedef logic [SwNum-1:0]          swVec_t;
	typedef logic [DipNum-1:0]         dipVec_t;
	typedef logic [CsrOffsetWidth-1:0] csrOffset_t;
	typedef logic [BlockIdWidth-1:0]   blockId_t;

	// ------------------------------
	// Address map
	// ------------------------------
	localparam blockId_t BlockAdrs    = 8'h01;
	localparam int       WriteFlagBit = 30;

	// Control registers, read/write
	localparam csrOffset_t OffOutCtrl = 8'h00;
	localparam csrOffset_t OffDir     = 8'h04;
	localparam csrOffset_t OffAltMode = 8'h08;
	// Status, read only
	localparam csrOffset_t OffGpioIn  = 8'h40;
	localparam csrOffset_t OffPushSw  = 8'h41;
	localparam csrOffset_t OffEdgeSw  = 8'h42;
	localparam csrOffset_t OffLongSw  = 8'h43;
	localparam csrOffset_t OffDipSw   = 8'h44;

	// ------------------------------
	// Switch filter
	// ------------------------------
	localparam int DebounceCycles = 4;
	localparam int LongCycles     = 16;
	localparam int DebCntWidth    = $clog2(DebounceCycles + 1);
	localparam int LongCntWidth   = $clog2(LongCycles + 1);

	typedef logic [DebCntWidth-1:0]  debCnt_t;
	typedef logic [LongCntWidth-1:0] longCnt_t;

	// Control register set
	typedef struct packed {
		gpioVec_t outCtrl;
		gpioVec_t dir;
		gpioVec_t altMode;
	} gpioCtrl_t;

	// Conditioned switch state
	typedef struct packed {
		swVec_t push;
		swVec_t edgePulse;
		swVec_t long;
	} swState_t;

	typedef enum logic [1:0] {
		Released,
		Pressed,
		Held
	} swPhase_t;

	// All pins input, alternate mode on
	localparam gpioCtrl_t CtrlResetValue = '{outCtrl: '0, dir: '1, altMode: '1};

endpackage

`default_nettype wire

/* gpioCsr.sv */
`default_nettype none

module gpioCsr (
	input  logic               iSCLK,
	input  logic               iSRST,
	// Bus
	input  gpioPkg::busWord_t  adrs,
	input  gpioPkg::busWord_t  wd,
	output gpioPkg::busWord_t  rd,
	// Control out to the pad block
	output gpioPkg::gpioCtrl_t ctrl,
	// Status in
	input  gpioPkg::gpioVec_t  gpioIn,
	input  gpioPkg::swState_t  swState,
	input  gpioPkg::dipVec_t   dipSw
);
	import gpioPkg::*;

	csrOffset_t offset;
	blockId_t   blockId;
	logic       writeFlag;
	logic       writeHit;
	gpioVec_t   wdPins;

	// ------------------------------
	// Write decode
	// ------------------------------

	// Low byte picks the register
	assign offset    = adrs[CsrOffsetWidth-1:0];
	assign blockId   = adrs[BlockIdLsb +: BlockIdWidth];
	assign writeFlag = adrs[WriteFlagBit];

	// Write strobe only for our own block
	assign writeHit = writeFlag && (blockId == BlockAdrs);

	// Only the pin-wide slice of the data is kept
	assign wdPins = wd[GpioWidth-1:0];

	// ------------------------------
	// Control registers
	// ------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			ctrl <= CtrlResetValue;
		end
		else if (writeHit)
		begin
			case (offset)
				OffOutCtrl:
				begin
					ctrl.outCtrl <= wdPins;
				end
				OffDir:
				begin
					ctrl.dir <= wdPins;
				end
				OffAltMode:
				begin
					ctrl.altMode <= wdPins;
				end
				default:
				begin
					// Other offsets are read only, nothing to store
					ctrl <= ctrl;
				end
			endcase
		end
	end

	// ------------------------------
	// Read mux
	// ------------------------------

	// Runs every cycle, result lands one cycle after the address
	// Only the offset byte is decoded, block ID ignored here
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			rd <= '0;
		end
		else
		begin
			case (offset)
				OffOutCtrl:
				begin
					rd <= {{(BusWidth - GpioWidth){1'b0}}, ctrl.outCtrl};
				end
				OffDir:
				begin
					rd <= {{(BusWidth - GpioWidth){1'b0}}, ctrl.dir};
				end
				OffAltMode:
				begin
					rd <= {{(BusWidth - GpioWidth){1'b0}}, ctrl.altMode};
				end
				// Synchronized pad levels
				OffGpioIn:
				begin
					rd <= {{(BusWidth - GpioWidth){1'b0}}, gpioIn};
				end
				// Debounced levels
				OffPushSw:
				begin
					rd <= {{(BusWidth - SwNum){1'b0}}, swState.push};
				end
				// One cycle pulse per press
				OffEdgeSw:
				begin
					rd <= {{(BusWidth - SwNum){1'b0}}, swState.edgePulse};
				end
				OffLongSw:
				begin
					rd <= {{(BusWidth - SwNum){1'b0}}, swState.long};
				end
				// DIP taken straight from the pins on read
				OffDipSw:
				begin
					rd <= {{(BusWidth - DipNum){1'b0}}, dipSw};
				end
				// Unmapped, echo write data
				default:
				begin
					rd <= wd;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* gpioPort.sv */
`default_nettype none

module gpioPort (
	input  logic               iSCLK,
	input  logic               iSRST,
	input  gpioPkg::gpioCtrl_t ctrl,
	// Alternate function drive
	input  gpioPkg::gpioVec_t  altOut,
	// Raw pad levels, not clock aligned
	input  gpioPkg::gpioVec_t  gpioPadIn,
	output gpioPkg::gpioVec_t  gpioPadOut,
	output gpioPkg::gpioVec_t  gpioPadOe,
	output gpioPkg::gpioVec_t  gpioIn
);
	import gpioPkg::*;

	gpioVec_t padMeta;

	// ------------------------------
	// Pad drive
	// ------------------------------

	// Per pin, alternate function or register value
	always_comb
	begin
		for (int i = 0; i < GpioWidth; i++)
		begin
			gpioPadOut[i] = ctrl.altMode[i] ? altOut[i] : ctrl.outCtrl[i];
		end
	end

	// Dir bit 1 means input, so the enable is the inverse
	assign gpioPadOe = ~ctrl.dir;

	// ------------------------------
	// Input sync
	// ------------------------------

	// Two flops into the clock domain
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			padMeta <= '0;
			gpioIn  <= '0;
		end
		else
		begin
			padMeta <= gpioPadIn;
			gpioIn  <= padMeta;
		end
	end

endmodule

`default_nettype wire

/* switchFilter.sv */
`default_nettype none

module switchFilter (
	input  logic              iSCLK,
	input  logic              iSRST,
	// Raw push switches, asynchronous and bouncing
	input  gpioPkg::swVec_t   switchRaw,
	output gpioPkg::swState_t swState
);
	import gpioPkg::*;

	swVec_t   swMeta;
	swVec_t   swSync;
	// Debounced level
	swVec_t   push;
	debCnt_t  debCnt [SwNum];
	swPhase_t phase [SwNum];
	longCnt_t longCnt [SwNum];
	swVec_t   edgePulse;
	swVec_t   longPress;

	// ------------------------------
	// Synchronizer
	// ------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			swMeta <= '0;
			swSync <= '0;
		end
		else
		begin
			swMeta <= switchRaw;
			swSync <= swMeta;
		end
	end

	// ------------------------------
	// Debounce
	// ------------------------------

	// Counter runs while the sample differs from the accepted level
	// Any matching sample restarts it, so short glitches die here
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			push <= '0;
			for (int i = 0; i < SwNum; i++)
			begin
				debCnt[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < SwNum; i++)
			begin
				if (swSync[i] == push[i])
				begin
					debCnt[i] <= '0;
				end
				else if (debCnt[i] == debCnt_t'(DebounceCycles - 1))
				begin
					// Stable long enough, take the new level
					push[i]   <= swSync[i];
					debCnt[i] <= '0;
				end
				else
				begin
					debCnt[i] <= debCnt[i] + debCnt_t'(1);
				end
			end
		end
	end

	// ------------------------------
	// Press phase
	// ------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			for (int i = 0; i < SwNum; i++)
			begin
				phase[i]   <= Released;
				longCnt[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < SwNum; i++)
			begin
				case (phase[i])
					Released:
					begin
						// Rising cycle already counts as the first one
						if (push[i])
						begin
							phase[i]   <= Pressed;
							longCnt[i] <= longCnt_t'(1);
						end
					end
					Pressed:
					begin
						if (!push[i])
						begin
							phase[i] <= Released;
						end
						else if (longCnt[i] == longCnt_t'(LongCycles - 1))
						begin
							phase[i] <= Held;
						end
						else
						begin
							longCnt[i] <= longCnt[i] + longCnt_t'(1);
						end
					end
					Held:
					begin
						if (!push[i])
						begin
							phase[i] <= Released;
						end
					end
					default:
					begin
						phase[i] <= Released;
					end
				endcase
			end
		end
	end

	// Edge is the Released to Pressed transition cycle
	// Long drops in the same cycle as push
	always_comb
	begin
		for (int i = 0; i < SwNum; i++)
		begin
			edgePulse[i] = push[i] && (phase[i] == Released);
			longPress[i] = push[i] && (phase[i] == Held);
		end
	end

	assign swState = '{push: push, edgePulse: edgePulse, long: longPress};

endmodule

`default_nettype wire

/* gpioTop.sv */
`default_nettype none

module gpioTop (
	input  logic              iSCLK,
	input  logic              iSRST,
	// Bus
	input  gpioPkg::busWord_t adrs,
	input  gpioPkg::busWord_t wd,
	output gpioPkg::busWord_t rd,
	// Pins
	input  gpioPkg::gpioVec_t gpioPadIn,
	output gpioPkg::gpioVec_t gpioPadOut,
	output gpioPkg::gpioVec_t gpioPadOe,
	input  gpioPkg::gpioVec_t altOut,
	// Switches
	input  gpioPkg::swVec_t   switchRaw,
	input  gpioPkg::dipVec_t  dipSw
);
	import gpioPkg::*;

	gpioCtrl_t ctrl;
	gpioVec_t  gpioIn;
	swState_t  swState;

	// ------------------------------
	// Register block
	// ------------------------------
	gpioCsr uCsr (
		.iSCLK   (iSCLK),
		.iSRST   (iSRST),
		.adrs    (adrs),
		.wd      (wd),
		.rd      (rd),
		.ctrl    (ctrl),
		.gpioIn  (gpioIn),
		.swState (swState),
		.dipSw   (dipSw)
	);

	// Pad drive and input sync
	gpioPort uPort (
		.iSCLK      (iSCLK),
		.iSRST      (iSRST),
		.ctrl       (ctrl),
		.altOut     (altOut),
		.gpioPadIn  (gpioPadIn),
		.gpioPadOut (gpioPadOut),
		.gpioPadOe  (gpioPadOe),
		.gpioIn     (gpioIn)
	);

	// Push switch conditioning
	switchFilter uSwitch (
		.iSCLK     (iSCLK),
		.iSRST     (iSRST),
		.switchRaw (switchRaw),
		.swState   (swState)
	);

endmodule

`default_nettype wire

/* tbGpio.sv */
`default_nettype none

module tbGpio;
	import gpioPkg::*;

	// One stimulus row, expected values sampled after the hold
	typedef struct packed {
		busWord_t adrs;
		busWord_t wd;
		logic     randWd;
		gpioVec_t padIn;
		gpioVec_t altOut;
		swVec_t   sw;
		dipVec_t  dip;
		int       hold;
		busWord_t expRd;
		gpioVec_t expOut;
		gpioVec_t expOe;
		swVec_t   expEdge;
	} row_t;

	logic     iSCLK;
	logic     iSRST;
	busWord_t adrs;
	busWord_t wd;
	busWord_t rd;
	gpioVec_t gpioPadIn;
	gpioVec_t gpioPadOut;
	gpioVec_t gpioPadOe;
	gpioVec_t altOut;
	swVec_t   switchRaw;
	dipVec_t  dipSw;
	row_t     stimTable [$];
	int       cycleCount;
	int       cycleLimit;

	gpioTop UUT (
		.iSCLK      (iSCLK),
		.iSRST      (iSRST),
		.adrs       (adrs),
		.wd         (wd),
		.rd         (rd),
		.gpioPadIn  (gpioPadIn),
		.gpioPadOut (gpioPadOut),
		.gpioPadOe  (gpioPadOe),
		.altOut     (altOut),
		.switchRaw  (switchRaw),
		.dipSw      (dipSw)
	);

	// ------------------------------
	// Clock and timeout
	// ------------------------------
	initial
	begin
		iSCLK = 1'b0;
		forever #50 iSCLK = ~iSCLK;
	end

	always @(posedge iSCLK)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit)
		begin
			failRun("Timeout, the test did not finish within the cycle limit");
		end
	end

	// ------------------------------
	// Failure and compare tasks
	// ------------------------------
	task automatic failRun(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic checkWord(input string name, input busWord_t expVal, input busWord_t actVal);
		if (expVal !== actVal)
		begin
			failRun($sformatf("[ERROR] %s expected 0x%h got 0x%h", name, expVal, actVal));
		end
	endtask

	task automatic checkPins(input string name, input gpioVec_t expVal, input gpioVec_t actVal);
		if (expVal !== actVal)
		begin
			failRun($sformatf("[ERROR] %s expected 0x%h got 0x%h", name, expVal, actVal));
		end
	endtask

	task automatic checkSw(input string name, input swVec_t expVal, input swVec_t actVal);
		if (expVal !== actVal)
		begin
			failRun($sformatf("[ERROR] %s expected 0x%h got 0x%h", name, expVal, actVal));
		end
	endtask

	// ------------------------------
	// Stimulus table
	// ------------------------------
	task automatic addRow(input busWord_t a, input busWord_t d, input logic rw,
		input gpioVec_t pin, input gpioVec_t alt, input swVec_t sw, input dipVec_t dip,
		input int hold, input busWord_t eRd, input gpioVec_t eOut, input gpioVec_t eOe,
		input swVec_t eEdge);
		row_t r;
		r = '{a, d, rw, pin, alt, sw, dip, hold, eRd, eOut, eOe, eEdge};
		stimTable.push_back(r);
	endtask

	// Write address is flag bit 30 plus block ID 0x01 plus offset
	task automatic loadTable();
		// Reset values, all pins input with alternate drive
		addRow(32'h0000_0000, 32'h0, 1'b0, 5'h00, 5'h00, 7'h00, 2'b00, 1, 32'h00, 5'h00, 5'h00, 7'h00);
		addRow(32'h0000_0004, 32'h0, 1'b0, 5'h00, 5'h00, 7'h00, 2'b00, 1, 32'h1F, 5'h00, 5'h00, 7'h00);
		addRow(32'h0000_0008, 32'h0, 1'b0, 5'h00, 5'h0A, 7'h00, 2'b00, 1, 32'h1F, 5'h0A, 5'h00, 7'h00);
		// Writes, second cycle reads back the new value
		addRow(32'h4000_0100, 32'hFFFF_FF15, 1'b0, 5'h00, 5'h0A, 7'h00, 2'b00, 2,
			32'h15, 5'h0A, 5'h00, 7'h00);
		addRow(32'h4000_0104, 32'h0C, 1'b0, 5'h00, 5'h0A, 7'h00, 2'b00, 2, 32'h0C, 5'h0A, 5'h13, 7'h00);
		addRow(32'h4000_0108, 32'h03, 1'b0, 5'h00, 5'h0A, 7'h00, 2'b00, 2, 32'h03, 5'h16, 5'h13, 7'h00);
		// Wrong block ID, then missing write flag
		addRow(32'h4000_0200, 32'h1F, 1'b0, 5'h00, 5'h0A, 7'h00, 2'b00, 2, 32'h15, 5'h16, 5'h13, 7'h00);
		addRow(32'h0000_0104, 32'h1F, 1'b0, 5'h00, 5'h0A, 7'h00, 2'b00, 2, 32'h0C, 5'h16, 5'h13, 7'h00);
		// Mixed pin drive
		addRow(32'h0000_0008, 32'h0, 1'b0, 5'h00, 5'h1D, 7'h00, 2'b00, 1, 32'h03, 5'h15, 5'h13, 7'h00);
		// Pad and DIP status
		addRow(32'h0000_0040, 32'h0, 1'b0, 5'h1B, 5'h1D, 7'h00, 2'b00, 3, 32'h1B, 5'h15, 5'h13, 7'h00);
		addRow(32'h0000_0044, 32'h0, 1'b0, 5'h1B, 5'h1D, 7'h00, 2'b10, 1, 32'h02, 5'h15, 5'h13, 7'h00);
		// Unmapped offsets echo random data
		addRow(32'h0000_0010, 32'h0, 1'b1, 5'h1B, 5'h1D, 7'h00, 2'b10, 1, 32'h0, 5'h15, 5'h13, 7'h00);
		addRow(32'h4000_0120, 32'h0, 1'b1, 5'h1B, 5'h1D, 7'h00, 2'b10, 1, 32'h0, 5'h15, 5'h13, 7'h00);
		// Short glitch never shows
		addRow(32'h0000_0041, 32'h0, 1'b0, 5'h1B, 5'h1D, 7'h01, 2'b10, 3, 32'h00, 5'h15, 5'h13, 7'h00);
		addRow(32'h0000_0042, 32'h0, 1'b0, 5'h1B, 5'h1D, 7'h00, 2'b10, 10, 32'h00, 5'h15, 5'h13, 7'h00);
		// Press two switches, one pulse each
		addRow(32'h0000_0042, 32'h0, 1'b0, 5'h1B, 5'h1D, 7'h09, 2'b10, 12, 32'h00, 5'h15, 5'h13, 7'h09);
		addRow(32'h0000_0041, 32'h0, 1'b0, 5'h1B, 5'h1D, 7'h09, 2'b10, 2, 32'h09, 5'h15, 5'h13, 7'h00);
		// Long press, then release clears it
		addRow(32'h0000_0043, 32'h0, 1'b0, 5'h1B, 5'h1D, 7'h09, 2'b10, 20, 32'h09, 5'h15, 5'h13, 7'h00);
		addRow(32'h0000_0043, 32'h0, 1'b0, 5'h1B, 5'h1D, 7'h00, 2'b10, 10, 32'h00, 5'h15, 5'h13, 7'h00);
		addRow(32'h0000_0041, 32'h0, 1'b0, 5'h1B, 5'h1D, 7'h00, 2'b10, 1, 32'h00, 5'h15, 5'h13, 7'h00);
		// Second press on the top switch
		addRow(32'h0000_0042, 32'h0, 1'b0, 5'h1B, 5'h1D, 7'h40, 2'b10, 12, 32'h00, 5'h15, 5'h13, 7'h40);
		addRow(32'h0000_0042, 32'h0, 1'b0, 5'h1B, 5'h1D, 7'h00, 2'b10, 12, 32'h00, 5'h15, 5'h13, 7'h00);
	endtask

	// Twice the held cycles plus margin for reset
	function automatic int computeLimit();
		int total;
		total = 0;
		foreach (stimTable[i])
		begin
			total = total + stimTable[i].hold;
		end
		return 2 * total + 100;
	endfunction

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial
	begin
		row_t     r;
		busWord_t rnd;
		swVec_t   once;
		swVec_t   many;
		int       edgeCnt [SwNum];
		iSRST      = 1'b1;
		adrs       = '0;
		wd         = '0;
		gpioPadIn  = '0;
		altOut     = '0;
		switchRaw  = '0;
		dipSw      = '0;
		cycleCount = 0;
		rnd = $urandom(32'h674652e2);
		loadTable();
		cycleLimit = computeLimit();
		repeat (10) @(negedge iSCLK);
		iSRST = 1'b0;
		foreach (stimTable[i])
		begin
			r = stimTable[i];
			if (r.randWd)
			begin
				rnd     = $urandom;
				r.wd    = rnd;
				r.expRd = rnd;
			end
			adrs      = r.adrs;
			wd        = r.wd;
			gpioPadIn = r.padIn;
			altOut    = r.altOut;
			switchRaw = r.sw;
			dipSw     = r.dip;
			for (int j = 0; j < SwNum; j++)
			begin
				edgeCnt[j] = 0;
			end
			// Poll the edge register on every cycle of the hold
			for (int h = 0; h < r.hold; h++)
			begin
				@(negedge iSCLK);
				if (adrs[CsrOffsetWidth-1:0] == OffEdgeSw)
				begin
					for (int j = 0; j < SwNum; j++)
					begin
						if (rd[j])
						begin
							edgeCnt[j] = edgeCnt[j] + 1;
						end
					end
				end
			end
			for (int j = 0; j < SwNum; j++)
			begin
				once[j] = (edgeCnt[j] == 1);
				many[j] = (edgeCnt[j] > 1);
			end
			checkWord("rd", r.expRd, rd);
			checkPins("gpioPadOut", r.expOut, gpioPadOut);
			checkPins("gpioPadOe", r.expOe, gpioPadOe);
			checkSw("edge count", r.expEdge, once);
			checkSw("edge repeat", '0, many);
		end
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
gpioPkg.sv
gpioCsr.sv
gpioPort.sv
switchFilter.sv
gpioTop.sv
tbGpio.sv

/* Makefile */
# Verilator simulation of the GPIO block

TOP := tbGpio

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module $(TOP) -f build.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir
